// File: all.f
verilog/fpMulPkg.sv
verilog/fpMulDecode.sv
verilog/fpMulExecute.sv
verilog/fpMulRound.sv
verilog/fpMulWbSlave.sv
verilog/fpMulTop.sv
verif/fpMulTb.sv

// File: runSim.sh
#!/bin/sh
# build and run the floating-point multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module fpMulTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VfpMulTb > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "simulation returned status $simStatus"
    exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: verif/fpMulPatterns.txt
# operand X  operand Y  mode  expected Z  expected flags, all in hex
# mode 0 NE 1 TZ 2 DN 3 UP 4 MM and flags hold ovrf in bit 0, udrf in bit 1, invalid in bit 2
40400000 40400000 0 41100000 0
40400000 40400000 1 41100000 0
40400000 40400000 2 41100000 0
40400000 40400000 3 41100000 0
40400000 40400000 4 41100000 0
C0400000 40400000 3 C1100000 0
3F800003 3FC00000 0 3FC00004 0
3F800003 3FC00000 1 3FC00004 0
3F800003 3FC00000 2 3FC00004 0
3F800003 3FC00000 3 3FC00005 0
3F800003 3FC00000 4 3FC00005 0
BF800003 3FC00000 0 BFC00004 0
BF800003 3FC00000 1 BFC00004 0
BF800003 3FC00000 2 BFC00005 0
BF800003 3FC00000 3 BFC00004 0
BF800003 3FC00000 4 BFC00005 0
3FB504F3 3FB504F3 3 40000000 0
3FB504F3 3FB504F3 1 3FFFFFFF 0
00000000 40400000 0 00000000 0
80000001 40400000 0 80000000 0
7F800000 C0400000 0 FF800000 0
7F800000 00000000 0 7FC00000 4
7FC00001 40400000 0 7FC00000 4
7F000000 40800000 0 7F800000 1
7F000000 40800000 1 7F7FFFFF 1
FF000000 40800000 2 FF800000 1
FF000000 40800000 3 FF7FFFFF 1
7F000000 40800000 4 7F800000 1
8D800000 0D800000 0 80000000 2

// File: verif/fpMulTb.sv
`timescale 1ns/1ps
`default_nettype none

module fpMulTb;

    localparam int addrWidth   = 3;
    localparam int ackTimeout  = 16;
    localparam int pollTimeout = 32;
    localparam int randomOps   = 40;

    logic                 clk;
    logic                 rst;
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [addrWidth-1:0] adr;
    logic [31:0]          datWr;
    logic [31:0]          datRd;
    logic                 ack;

    fpMulTop #(
        .addrWidth (addrWidth)
    ) i_dut (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .datWr (datWr),
        .datRd (datRd),
        .ack   (ack)
    );

    always #50 clk = !clk;

    task automatic stopOnError(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            stopOnError($sformatf("MISMATCH %s expected %08h actual %08h",
                                  name, expected, actual));
        end
    endtask

    task automatic compareFlags(input string name, input fpMulPkg::mulResult_t expected,
                                input fpMulPkg::mulResult_t actual);
        if ({actual.ovrf, actual.udrf, actual.invalid}
                !== {expected.ovrf, expected.udrf, expected.invalid}) begin
            stopOnError($sformatf("MISMATCH %s flags (ovrf udrf invalid) expected %03b actual %03b",
                                  name, {expected.ovrf, expected.udrf, expected.invalid},
                                  {actual.ovrf, actual.udrf, actual.invalid}));
        end
    endtask

    // one classic cycle, inputs change on the falling edge
    task automatic busAccess(input logic write, input int unsigned addr,
                             input logic [31:0] wrData, output logic [31:0] rdData);
        int waited;
        waited = 0;
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = addr[addrWidth-1:0];
        datWr = wrData;
        @(negedge clk);
        while (!ack) begin
            if (waited == ackTimeout) begin
                stopOnError($sformatf("no ack for an access to address %0d", addr));
            end
            waited++;
            @(negedge clk);
        end
        rdData = datRd;
        // cyc and stb stay up over the ack edge
        @(negedge clk);
        if (ack) begin
            stopOnError("ack stayed high for a second cycle");
        end
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
    endtask

    task automatic busWrite(input int unsigned addr, input logic [31:0] data);
        logic [31:0] unused;
        busAccess(1'b1, addr, data, unused);
    endtask

    task automatic busRead(input int unsigned addr, output logic [31:0] data);
        busAccess(1'b0, addr, 32'd0, data);
    endtask

    task automatic waitDone(output logic [31:0] status);
        int polls;
        polls = 0;
        busRead(fpMulPkg::REG_STATUS, status);
        while (!status[fpMulPkg::STAT_DONE]) begin
            if (polls == pollTimeout) begin
                stopOnError("done bit never came up after a start");
            end
            polls++;
            busRead(fpMulPkg::REG_STATUS, status);
        end
    endtask

    task automatic runOp(input string name, input logic [31:0] x, input logic [31:0] y,
                         input logic [2:0] mode, input logic [31:0] expValue,
                         input logic [2:0] expFlags);
        logic [31:0]          status;
        logic [31:0]          value;
        fpMulPkg::mulResult_t expected;
        fpMulPkg::mulResult_t actual;
        busWrite(fpMulPkg::REG_X, x);
        busWrite(fpMulPkg::REG_Y, y);
        busWrite(fpMulPkg::REG_CTRL, {29'd0, mode});
        waitDone(status);
        busRead(fpMulPkg::REG_RESULT, value);
        expected         = '0;
        expected.value   = expValue;
        expected.ovrf    = expFlags[0];
        expected.udrf    = expFlags[1];
        expected.invalid = expFlags[2];
        actual           = '0;
        actual.value     = value;
        actual.ovrf      = status[fpMulPkg::STAT_OVRF];
        actual.udrf      = status[fpMulPkg::STAT_UDRF];
        actual.invalid   = status[fpMulPkg::STAT_INVALID];
        compareValue(name, expValue, value);
        compareFlags(name, expected, actual);
    endtask

    // normal operands only, so no specials and no range limits
    function automatic logic [31:0] expectedProduct(input logic [31:0] x, input logic [31:0] y,
                                                    input logic [2:0] mode);
        logic [63:0] full;
        logic [63:0] kept;
        logic [63:0] rest;
        int          shift;
        int          expo;
        logic        sign;
        logic        guard;
        logic        sticky;
        logic        up;
        full   = {40'd0, 1'b1, x[22:0]};
        full   = full * {40'd0, 1'b1, y[22:0]};
        sign   = x[31] ^ y[31];
        expo   = int'(x[30:23]) + int'(y[30:23]) - 127;
        // significand product sits in [1, 4) times 2^46
        shift  = (full >= 64'h8000_0000_0000) ? 24 : 23;
        expo   = expo + shift - 23;
        kept   = full >> shift;
        guard  = full[shift-1];
        rest   = full & ((64'd1 << (shift - 1)) - 64'd1);
        sticky = (rest != 64'd0);
        case (mode)
            3'd1:    up = 1'b0;
            3'd2:    up = sign && (guard || sticky);
            3'd3:    up = !sign && (guard || sticky);
            3'd4:    up = guard;
            default: up = guard && (sticky || kept[0]);
        endcase
        kept = kept + {63'd0, up};
        if (kept >= (64'd1 << 24)) begin
            kept = kept >> 1;
            expo = expo + 1;
        end
        return {sign, expo[7:0], kept[22:0]};
    endfunction

    function automatic logic [31:0] randomOperand();
        logic [7:0] expo;
        expo = 8'($urandom_range(150, 100));
        return {1'($urandom), expo, 23'($urandom)};
    endfunction

    initial begin
        int          fd;
        int          fields;
        int          lineNo;
        int          patterns;
        string       line;
        logic [31:0] rdData;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] z;
        logic [2:0]  mode;
        logic [2:0]  flags;
        clk    = 1'b0;
        rst    = 1'b1;
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
        adr    = '0;
        datWr  = '0;
        void'($urandom(32'h5df25df6));
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // register file and bus behavior
        busRead(fpMulPkg::REG_STATUS, rdData);
        compareValue("status after reset", 32'd0, rdData);
        busWrite(fpMulPkg::REG_X, 32'h12345678);
        busRead(fpMulPkg::REG_X, rdData);
        compareValue("readback of X", 32'h12345678, rdData);
        busWrite(fpMulPkg::REG_Y, 32'h9ABCDEF0);
        busRead(fpMulPkg::REG_Y, rdData);
        compareValue("readback of Y", 32'h9ABCDEF0, rdData);
        busWrite(fpMulPkg::REG_CTRL, 32'h4);
        busRead(fpMulPkg::REG_CTRL, rdData);
        compareValue("readback of CTRL", 32'h4, rdData);
        waitDone(rdData);
        busRead(5, rdData);
        compareValue("unmapped address 5", 32'd0, rdData);
        busRead(7, rdData);
        compareValue("unmapped address 7", 32'd0, rdData);

        fd = $fopen("verif/fpMulPatterns.txt", "r");
        if (fd == 0) begin
            stopOnError("cannot open verif/fpMulPatterns.txt");
        end
        lineNo   = 0;
        patterns = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            lineNo++;
            if (line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%h %h %h %h %h", x, y, mode, z, flags);
                if (fields != 5) begin
                    stopOnError($sformatf("pattern line %0d has %0d fields", lineNo, fields));
                end
                runOp($sformatf("pattern line %0d", lineNo), x, y, mode, z, flags);
                patterns++;
            end
        end
        $fclose(fd);
        if (patterns == 0) begin
            stopOnError("no patterns were read from the pattern file");
        end

        // codes 5 to 7 included to cover the nearest-even fallback
        for (int i = 0; i < randomOps; i++) begin
            x    = randomOperand();
            y    = randomOperand();
            mode = 3'($urandom_range(7, 0));
            runOp($sformatf("random op %0d", i), x, y, mode, expectedProduct(x, y, mode), 3'b000);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/fpMulDecode.sv
`timescale 1ns/1ps
`default_nettype none

module fpMulDecode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic [31:0]            opX,
    input  logic [31:0]            opY,
    input  fpMulPkg::roundMode_e   mode,
    output fpMulPkg::decodedOp_t   dec
);

    fpMulPkg::decodedOp_t decNext;

    // exponent field alone decides zero, inf and nan
    function automatic fpMulPkg::opClass_e classify(input logic [31:0] op);
        if (op[30:23] == 8'd0) begin
            return fpMulPkg::CLS_ZERO;
        end else if (op[30:23] == 8'hFF) begin
            return (op[22:0] == 23'd0) ? fpMulPkg::CLS_INF : fpMulPkg::CLS_NAN;
        end
        return fpMulPkg::CLS_NORMAL;
    endfunction

    // subnormal fractions are dropped so zero carries no mantissa
    function automatic logic [23:0] significand(input logic [31:0] op);
        if (op[30:23] == 8'd0) begin
            return 24'd0;
        end
        return {1'b1, op[22:0]};
    endfunction

    always_comb begin
        decNext.valid  = start;
        decNext.sign   = opX[31] ^ opY[31];
        decNext.expSum = $signed({2'b00, opX[30:23]}) + $signed({2'b00, opY[30:23]})
                         - fpMulPkg::EXP_BIAS;
        decNext.manX   = significand(opX);
        decNext.manY   = significand(opY);
        decNext.clsX   = classify(opX);
        decNext.clsY   = classify(opY);
        decNext.mode   = mode;
    end

    always_ff @(posedge clk) begin
        dec <= decNext;
        if (rst) begin
            dec.valid <= 1'b0;
        end
    end

    zeroHasNoMantissa: assert property (@(posedge clk) disable iff (rst)
        dec.valid |-> ((dec.clsX != fpMulPkg::CLS_ZERO) || (dec.manX == 24'd0))
                   && ((dec.clsY != fpMulPkg::CLS_ZERO) || (dec.manY == 24'd0)));

endmodule

`default_nettype wire

// File: verilog/fpMulExecute.sv
`timescale 1ns/1ps
`default_nettype none

module fpMulExecute (
    input  logic                   clk,
    input  logic                   rst,
    input  fpMulPkg::decodedOp_t   dec,
    output fpMulPkg::productOp_t   prod
);

    logic [47:0]          prodFull;
    logic                 xZero;
    logic                 yZero;
    logic                 xInf;
    logic                 yInf;
    logic                 anyNan;
    fpMulPkg::productOp_t prodNext;

    assign prodFull = dec.manX * dec.manY;

    assign xZero  = (dec.clsX == fpMulPkg::CLS_ZERO);
    assign yZero  = (dec.clsY == fpMulPkg::CLS_ZERO);
    assign xInf   = (dec.clsX == fpMulPkg::CLS_INF);
    assign yInf   = (dec.clsY == fpMulPkg::CLS_INF);
    assign anyNan = (dec.clsX == fpMulPkg::CLS_NAN) || (dec.clsY == fpMulPkg::CLS_NAN);

    always_comb begin
        prodNext.valid = dec.valid;
        prodNext.sign  = dec.sign;
        prodNext.mode  = dec.mode;

        // product of two 1.x values lies in [1, 4)
        if (prodFull[47]) begin
            prodNext.manNorm = {prodFull[47:24], prodFull[23], |prodFull[22:0]};
            prodNext.expNorm = dec.expSum + 10'sd1;
        end else begin
            prodNext.manNorm = {prodFull[46:23], prodFull[22], |prodFull[21:0]};
            prodNext.expNorm = dec.expSum;
        end

        // nan first, inf*0 is also nan
        if (anyNan || (xInf && yZero) || (yInf && xZero)) begin
            prodNext.special = fpMulPkg::SPC_NAN;
        end else if (xInf || yInf) begin
            prodNext.special = fpMulPkg::SPC_INF;
        end else if (xZero || yZero) begin
            prodNext.special = fpMulPkg::SPC_ZERO;
        end else begin
            prodNext.special = fpMulPkg::SPC_NONE;
        end
    end

    always_ff @(posedge clk) begin
        prod <= prodNext;
        if (rst) begin
            prod.valid <= 1'b0;
        end
    end

    // normal operands must leave a leading one after the one-bit shift
    normalizedMsb: assert property (@(posedge clk) disable iff (rst)
        dec.valid && (dec.clsX == fpMulPkg::CLS_NORMAL) && (dec.clsY == fpMulPkg::CLS_NORMAL)
        |=> prod.manNorm[25]);

endmodule

`default_nettype wire

// File: verilog/fpMulPkg.sv
`default_nettype none

package fpMulPkg;

    // codes 5 to 7 fall back to nearest-even in the rounder
    typedef enum logic [2:0] {
        RND_NE = 3'd0,
        RND_TZ = 3'd1,
        RND_DN = 3'd2,
        RND_UP = 3'd3,
        RND_MM = 3'd4
    } roundMode_e;

    // subnormals are folded into CLS_ZERO
    typedef enum logic [1:0] {
        CLS_ZERO   = 2'd0,
        CLS_NORMAL = 2'd1,
        CLS_INF    = 2'd2,
        CLS_NAN    = 2'd3
    } opClass_e;

    typedef enum logic [1:0] {
        SPC_NONE = 2'd0,
        SPC_ZERO = 2'd1,
        SPC_INF  = 2'd2,
        SPC_NAN  = 2'd3
    } special_e;

    typedef struct packed {
        logic              valid;
        logic              sign;
        logic signed [9:0] expSum;
        logic [23:0]       manX;
        logic [23:0]       manY;
        opClass_e          clsX;
        opClass_e          clsY;
        roundMode_e        mode;
    } decodedOp_t;

    // manNorm holds 24 significant bits, then guard, then sticky
    typedef struct packed {
        logic              valid;
        logic              sign;
        logic signed [9:0] expNorm;
        logic [25:0]       manNorm;
        special_e          special;
        roundMode_e        mode;
    } productOp_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] value;
        logic        ovrf;
        logic        udrf;
        logic        invalid;
    } mulResult_t;

    // word addresses
    localparam int unsigned REG_X      = 0;
    localparam int unsigned REG_Y      = 1;
    localparam int unsigned REG_CTRL   = 2;
    localparam int unsigned REG_RESULT = 3;
    localparam int unsigned REG_STATUS = 4;

    // status register bits
    localparam int unsigned STAT_DONE    = 0;
    localparam int unsigned STAT_OVRF    = 1;
    localparam int unsigned STAT_UDRF    = 2;
    localparam int unsigned STAT_INVALID = 3;

    localparam logic signed [9:0] EXP_BIAS  = 10'sd127;
    localparam logic [31:0]       CANON_NAN = 32'h7FC00000;

endpackage

`default_nettype wire

// File: verilog/fpMulRound.sv
`timescale 1ns/1ps
`default_nettype none

module fpMulRound (
    input  logic                   clk,
    input  logic                   rst,
    input  fpMulPkg::productOp_t   prod,
    output fpMulPkg::mulResult_t   res
);

    logic                 lsb;
    logic                 guard;
    logic                 sticky;
    logic                 roundUp;
    logic                 overflowToInf;
    logic [23:0]          fracSum;
    logic signed [9:0]    expFinal;
    fpMulPkg::mulResult_t resNext;

    assign lsb    = prod.manNorm[2];
    assign guard  = prod.manNorm[1];
    assign sticky = prod.manNorm[0];

    always_comb begin
        case (prod.mode)
            fpMulPkg::RND_TZ: begin
                roundUp       = 1'b0;
                overflowToInf = 1'b0;
            end
            fpMulPkg::RND_DN: begin
                roundUp       = prod.sign && (guard || sticky);
                overflowToInf = prod.sign;
            end
            fpMulPkg::RND_UP: begin
                roundUp       = !prod.sign && (guard || sticky);
                overflowToInf = !prod.sign;
            end
            fpMulPkg::RND_MM: begin
                roundUp       = guard;
                overflowToInf = 1'b1;
            end
            // nearest-even, also for the unused codes
            default: begin
                roundUp       = guard && (sticky || lsb);
                overflowToInf = 1'b1;
            end
        endcase
    end

    // a carry out of the fraction leaves it all zero, so only the exponent moves
    assign fracSum  = {1'b0, prod.manNorm[24:2]} + {23'd0, roundUp};
    assign expFinal = $signed(prod.expNorm) + $signed({9'd0, fracSum[23]});

    always_comb begin
        resNext.valid   = prod.valid;
        resNext.ovrf    = 1'b0;
        resNext.udrf    = 1'b0;
        resNext.invalid = 1'b0;
        resNext.value   = {prod.sign, expFinal[7:0], fracSum[22:0]};

        case (prod.special)
            fpMulPkg::SPC_NAN: begin
                resNext.value   = fpMulPkg::CANON_NAN;
                resNext.invalid = 1'b1;
            end
            fpMulPkg::SPC_INF: begin
                resNext.value = {prod.sign, 8'hFF, 23'd0};
            end
            fpMulPkg::SPC_ZERO: begin
                resNext.value = {prod.sign, 31'd0};
            end
            default: begin
                if (expFinal >= 10'sd255) begin
                    resNext.ovrf  = 1'b1;
                    // largest finite magnitude when the mode rounds toward zero
                    resNext.value = overflowToInf ? {prod.sign, 8'hFF, 23'd0}
                                                  : {prod.sign, 8'hFE, 23'h7FFFFF};
                end else if (expFinal <= 10'sd0) begin
                    resNext.udrf  = 1'b1;
                    resNext.value = {prod.sign, 31'd0};
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        res <= resNext;
        if (rst) begin
            res.valid <= 1'b0;
        end
    end

    signKept: assert property (@(posedge clk) disable iff (rst)
        prod.valid |=> res.invalid || (res.value[31] == $past(prod.sign)));

endmodule

`default_nettype wire

// File: verilog/fpMulTop.sv
`timescale 1ns/1ps
`default_nettype none

module fpMulTop #(
    parameter int addrWidth = 3
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  logic [addrWidth-1:0]   adr,
    input  logic [31:0]            datWr,
    output logic [31:0]            datRd,
    output logic                   ack
);

    logic                 start;
    logic [31:0]          opX;
    logic [31:0]          opY;
    fpMulPkg::roundMode_e mode;
    fpMulPkg::decodedOp_t dec;
    fpMulPkg::productOp_t prod;
    fpMulPkg::mulResult_t res;

    fpMulWbSlave #(
        .addrWidth (addrWidth)
    ) iSlave (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .datWr (datWr),
        .res   (res),
        .datRd (datRd),
        .ack   (ack),
        .start (start),
        .opX   (opX),
        .opY   (opY),
        .mode  (mode)
    );

    // decode, multiply and round, one register each
    fpMulDecode iDecode (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .opX   (opX),
        .opY   (opY),
        .mode  (mode),
        .dec   (dec)
    );

    fpMulExecute iExecute (
        .clk  (clk),
        .rst  (rst),
        .dec  (dec),
        .prod (prod)
    );

    fpMulRound iRound (
        .clk  (clk),
        .rst  (rst),
        .prod (prod),
        .res  (res)
    );

endmodule

`default_nettype wire

// File: verilog/fpMulWbSlave.sv
`timescale 1ns/1ps
`default_nettype none

module fpMulWbSlave #(
    parameter int addrWidth = 3
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  logic [addrWidth-1:0]   adr,
    input  logic [31:0]            datWr,
    input  fpMulPkg::mulResult_t   res,
    output logic [31:0]            datRd,
    output logic                   ack,
    output logic                   start,
    output logic [31:0]            opX,
    output logic [31:0]            opY,
    output fpMulPkg::roundMode_e   mode
);

    logic        accept;
    logic        wrAccess;
    logic        ctrlWrite;
    logic [31:0] resultReg;
    logic        done;
    logic        ovrfFlag;
    logic        udrfFlag;
    logic        invalidFlag;
    logic [31:0] statusWord;

    // first cycle of an access, the !ack term keeps ack to one cycle
    assign accept    = cyc && stb && !ack;
    assign wrAccess  = accept && we;
    assign ctrlWrite = wrAccess && (adr == addrWidth'(fpMulPkg::REG_CTRL));

    always_ff @(posedge clk) begin
        if (rst) begin
            ack   <= 1'b0;
            start <= 1'b0;
        end else begin
            ack   <= accept;
            start <= ctrlWrite;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            opX  <= '0;
            opY  <= '0;
            mode <= fpMulPkg::RND_NE;
        end else if (wrAccess) begin
            case (adr)
                addrWidth'(fpMulPkg::REG_X):    opX  <= datWr;
                addrWidth'(fpMulPkg::REG_Y):    opY  <= datWr;
                addrWidth'(fpMulPkg::REG_CTRL): mode <= fpMulPkg::roundMode_e'(datWr[2:0]);
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resultReg   <= '0;
            done        <= 1'b0;
            ovrfFlag    <= 1'b0;
            udrfFlag    <= 1'b0;
            invalidFlag <= 1'b0;
        end else begin
            if (res.valid) begin
                resultReg   <= res.value;
                ovrfFlag    <= res.ovrf;
                udrfFlag    <= res.udrf;
                invalidFlag <= res.invalid;
                done        <= 1'b1;
            end
            // a new request wins over a result landing in the same cycle
            if (ctrlWrite) begin
                done <= 1'b0;
            end
        end
    end

    always_comb begin
        statusWord                             = '0;
        statusWord[fpMulPkg::STAT_DONE]    = done;
        statusWord[fpMulPkg::STAT_OVRF]    = ovrfFlag;
        statusWord[fpMulPkg::STAT_UDRF]    = udrfFlag;
        statusWord[fpMulPkg::STAT_INVALID] = invalidFlag;

        case (adr)
            addrWidth'(fpMulPkg::REG_X):      datRd = opX;
            addrWidth'(fpMulPkg::REG_Y):      datRd = opY;
            addrWidth'(fpMulPkg::REG_CTRL):   datRd = {29'd0, mode};
            addrWidth'(fpMulPkg::REG_RESULT): datRd = resultReg;
            addrWidth'(fpMulPkg::REG_STATUS): datRd = statusWord;
            default:                          datRd = '0;
        endcase
    end

    ackOneCycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack);

endmodule

`default_nettype wire
